/* logic/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // geometry of the 2-way cache
    localparam int INDEX_W  = 8;
    localparam int TAG_W    = 20;
    localparam int OFFSET_W = 4;
    localparam int WORD_W   = 32;
    localparam int BANKS    = 4;                  // words per line
    localparam int SETS     = 1 << INDEX_W;
    localparam int BLOCK_W  = WORD_W * BANKS;

    localparam logic [2:0] LFSR_SEED = 3'b111;    // victim lfsr after reset

    typedef logic [INDEX_W-1:0]       index_t;
    typedef logic [TAG_W-1:0]         tag_t;
    typedef logic [OFFSET_W-1:0]      offset_t;
    typedef logic [WORD_W-1:0]        word_t;
    typedef logic [WORD_W/8-1:0]      strb_t;
    typedef logic [$clog2(BANKS)-1:0] bank_t;
    typedef logic [BLOCK_W-1:0]       block_t;     // word 0 in the low bits

    // tag-valid ram entry
    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_t;

    typedef strb_t [BANKS-1:0] bank_strb_t;

    // one-hot main fsm states
    typedef enum logic [4:0] {
        IDLE    = 5'b00001,
        LOOKUP  = 5'b00010,
        MISS    = 5'b00100,
        REPLACE = 5'b01000,
        REFILL  = 5'b10000
    } cache_state_t;

endpackage

`default_nettype wire

/* logic/sync_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_ram import cache_pkg::*; #(
    parameter type entry_t = word_t,
    parameter int  DEPTH   = SETS
) (
    input  logic                            clk,
    input  logic                            en,
    input  index_t                          addr,
    input  logic [($bits(entry_t)+7)/8-1:0] we,     // one enable per byte lane
    input  entry_t                          wdata,
    output entry_t                          rdata
);

    logic [$bits(entry_t)-1:0] mem [DEPTH];

    // read-first, output held while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= entry_t'(mem[addr]);
            for (int i = 0; i < $bits(entry_t); i++) begin
                if (we[i/8]) begin
                    mem[addr][i] <= wdata[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/cache_way.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_way import cache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       ram_en,
    input  index_t     ram_addr,
    input  tag_t       req_tag,
    input  logic       tag_we,
    input  bank_strb_t bank_we,
    input  word_t      bank_wdata,
    input  logic       dirty_set,
    input  logic       dirty_clr,
    output logic       hit,
    output tag_t       tag_q,
    output block_t     block,
    output logic       dirty
);

    tagv_t           tagv_wdata;
    tagv_t           tagv_q;
    logic [SETS-1:0] dirty_bits;

    assign tagv_wdata = tagv_t'{tag: req_tag, valid: 1'b1};   // refill always validates

    sync_ram #(
        .entry_t (tagv_t),
        .DEPTH   (SETS)
    ) u_tagv (
        .clk   (clk),
        .en    (ram_en),
        .addr  (ram_addr),
        .we    ({(($bits(tagv_t) + 7) / 8){tag_we}}),
        .wdata (tagv_wdata),
        .rdata (tagv_q)
    );

    // one ram per word of the line
    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        sync_ram #(
            .entry_t (word_t),
            .DEPTH   (SETS)
        ) u_bank (
            .clk   (clk),
            .en    (ram_en),
            .addr  (ram_addr),
            .we    (bank_we[b]),
            .wdata (bank_wdata),
            .rdata (block[b*WORD_W +: WORD_W])
        );
    end

    // dirty flags, sync write, async read
    always_ff @(posedge clk) begin
        if (reset) begin
            dirty_bits <= '0;
        end else if (dirty_set) begin
            dirty_bits[ram_addr] <= 1'b1;
        end else if (dirty_clr) begin
            dirty_bits[ram_addr] <= 1'b0;
        end
    end

    assign hit   = tagv_q.valid && (tagv_q.tag == req_tag);
    assign tag_q = tagv_q.tag;
    assign dirty = dirty_bits[ram_addr] && tagv_q.valid;   // stale bit on invalid line ignored

endmodule

`default_nettype wire

/* logic/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl import cache_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic valid,
    input  logic req_op,          // 1 = store
    input  logic hit,
    input  logic victim_dirty,
    input  logic write_busy,
    input  logic beat_match,
    input  logic wr_rdy,
    input  logic rd_rdy,
    input  logic ret_valid,
    input  logic ret_last,
    output logic addr_ok,
    output logic lookup_en,
    output logic in_refill,
    output logic data_ok,
    output logic wr_req,
    output logic rd_req
);

    cache_state_t state;
    cache_state_t state_next;

    // new requests only from idle, and not while a store hit commits
    assign addr_ok   = (state == IDLE) && !write_busy;
    assign lookup_en = valid && addr_ok;
    assign in_refill = (state == REFILL);

    assign wr_req = (state == MISS) && victim_dirty;   // held until wr_rdy
    assign rd_req = (state == REPLACE);                // held until rd_rdy

    // load finishes on its critical beat, store on the last beat
    assign data_ok = ((state == LOOKUP) && hit) ||
                     (in_refill && ret_valid && (req_op ? ret_last : beat_match));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (lookup_en) begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                state_next = hit ? IDLE : MISS;
            end
            MISS: begin
                if (!victim_dirty || wr_rdy) begin   // clean victim skips write-back
                    state_next = REPLACE;
                end
            end
            REPLACE: begin
                if (rd_rdy) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid && ret_last) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

endmodule

`default_nettype wire

/* logic/miss_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module miss_sequencer import cache_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  in_refill,
    input  logic  ret_valid,
    input  logic  ret_last,
    output bank_t beat,
    output logic  victim_way
);

    logic [2:0] lfsr;

    // word number of the next refill beat, wraps after the last one
    always_ff @(posedge clk) begin
        if (reset) begin
            beat <= '0;
        end else if (in_refill && ret_valid) begin
            beat <= beat + 1'b1;
        end
    end

    // one step per finished refill
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else if (in_refill && ret_valid && ret_last) begin
            lfsr <= {lfsr[0], lfsr[2] ^ lfsr[0], lfsr[1]};
        end
    end

    assign victim_way = lfsr[0];

endmodule

`default_nettype wire

/* logic/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    // cpu side
    input  logic        valid,
    input  logic        op,          // 1 = store
    input  index_t      index,
    input  tag_t        tag,
    input  offset_t     offset,
    input  strb_t       wstrb,
    input  word_t       wdata,
    output logic        addr_ok,
    output logic        data_ok,
    output word_t       rdata,
    // bus read
    output logic        rd_req,
    output logic [31:0] rd_addr,
    input  logic        rd_rdy,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  word_t       ret_data,
    // bus write-back
    output logic        wr_req,
    output logic [31:0] wr_addr,
    output block_t      wr_data,
    input  logic        wr_rdy
);

    // request buffer
    logic    req_op;
    index_t  req_index;
    tag_t    req_tag;
    offset_t req_offset;
    strb_t   req_wstrb;
    word_t   req_wdata;
    bank_t   req_word;

    // write buffer
    logic    wb_busy;
    logic    wb_capture;
    logic    wb_way;
    bank_t   wb_bank;
    index_t  wb_index;
    strb_t   wb_strb;
    word_t   wb_data;

    logic    lookup_en;
    logic    in_refill;
    logic    hit;
    logic    victim_way;
    logic    victim_dirty;
    logic    beat_match;
    logic    req_active;
    logic    ram_en;
    bank_t   beat;
    index_t  ram_addr;
    word_t   merged_word;
    word_t   refill_word;
    word_t   bank_wdata;
    word_t   hit_word;

    logic   [1:0] way_hit;
    logic   [1:0] way_dirty;
    tag_t   [1:0] way_tag;
    block_t [1:0] way_block;

    cache_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .valid        (valid),
        .req_op       (req_op),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .write_busy   (wb_busy),
        .beat_match   (beat_match),
        .wr_rdy       (wr_rdy),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .addr_ok      (addr_ok),
        .lookup_en    (lookup_en),
        .in_refill    (in_refill),
        .data_ok      (data_ok),
        .wr_req       (wr_req),
        .rd_req       (rd_req)
    );

    miss_sequencer u_seq (
        .clk        (clk),
        .reset      (reset),
        .in_refill  (in_refill),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .beat       (beat),
        .victim_way (victim_way)
    );

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            req_op     <= op;
            req_index  <= index;
            req_tag    <= tag;
            req_offset <= offset;
            req_wstrb  <= wstrb;
            req_wdata  <= wdata;
        end
    end

    assign req_word   = req_offset[OFFSET_W-1:2];
    assign beat_match = (beat == req_word);
    assign hit        = |way_hit;

    // store hit, captured at the end of lookup and committed the cycle after
    assign wb_capture = data_ok && req_op && !in_refill;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_busy <= 1'b0;
        end else begin
            wb_busy <= wb_capture;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_capture) begin
            wb_way   <= way_hit[1];
            wb_bank  <= req_word;
            wb_index <= req_index;
            wb_strb  <= req_wstrb;
            wb_data  <= req_wdata;
        end
    end

    // every state but idle works on the buffered request
    assign req_active = !addr_ok && !wb_busy;
    assign ram_en     = req_active || wb_busy || lookup_en;

    always_comb begin
        if (req_active) begin
            ram_addr = req_index;
        end else if (wb_busy) begin
            ram_addr = wb_index;
        end else begin
            ram_addr = index;
        end
    end

    // store miss data merged into its critical word
    always_comb begin
        for (int i = 0; i < WORD_W / 8; i++) begin
            merged_word[i*8 +: 8] = req_wstrb[i] ? req_wdata[i*8 +: 8] : ret_data[i*8 +: 8];
        end
    end

    assign refill_word = (req_op && beat_match) ? merged_word : ret_data;
    assign bank_wdata  = in_refill ? refill_word : wb_data;

    for (genvar w = 0; w < 2; w++) begin : g_way
        bank_strb_t bank_we;
        logic       commit_here;
        logic       fill_here;
        logic       fill_done;

        assign commit_here = wb_busy && (wb_way == 1'(w));
        assign fill_here   = in_refill && ret_valid && (victim_way == 1'(w));
        assign fill_done   = fill_here && ret_last;

        always_comb begin
            bank_we = '0;
            if (commit_here) begin
                bank_we[wb_bank] = wb_strb;
            end
            if (fill_here) begin
                bank_we[beat] = '1;      // whole word per beat
            end
        end

        cache_way u_way (
            .clk        (clk),
            .reset      (reset),
            .ram_en     (ram_en),
            .ram_addr   (ram_addr),
            .req_tag    (req_tag),
            .tag_we     (fill_done),
            .bank_we    (bank_we),
            .bank_wdata (bank_wdata),
            .dirty_set  (commit_here || (fill_done && req_op)),
            .dirty_clr  (fill_done && !req_op),
            .hit        (way_hit[w]),
            .tag_q      (way_tag[w]),
            .block      (way_block[w]),
            .dirty      (way_dirty[w])
        );
    end

    // load data, from the hit way or straight off the bus
    assign hit_word = way_hit[1] ? way_block[1][req_word*WORD_W +: WORD_W]
                                 : way_block[0][req_word*WORD_W +: WORD_W];
    assign rdata    = in_refill ? ret_data : hit_word;

    assign victim_dirty = way_dirty[victim_way];

    assign rd_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};              // line aligned
    assign wr_addr = {way_tag[victim_way], req_index, {OFFSET_W{1'b0}}};
    assign wr_data = way_block[victim_way];

endmodule

`default_nettype wire

/* tb/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;     // 10 ns period
    end

    // reset released just after a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* tb/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tb import cache_pkg::*; ();

    localparam int RANDOM_OPS  = 300;
    localparam int DIRECT_OPS  = 20;
    localparam int MISS_CYCLES = 40;             // worst-case miss with stalls
    localparam int WATCHDOG_NS = (RANDOM_OPS + DIRECT_OPS) * MISS_CYCLES * 10 + 2000;
    localparam int MEM_WORDS   = 4096;           // tags 0 to 3 over all sets
    localparam int LCG_SEED    = 57805;

    logic        clk;
    logic        reset;
    logic        valid;
    logic        op;
    index_t      index;
    tag_t        tag;
    offset_t     offset;
    strb_t       wstrb;
    word_t       wdata;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    word_t       ret_data;
    logic        wr_req;
    logic [31:0] wr_addr;
    block_t      wr_data;
    logic        wr_rdy;

    word_t       bus_mem [MEM_WORDS];
    word_t       ref_mem [MEM_WORDS];        // expected memory
    logic [31:0] lcg_state = LCG_SEED;
    string       test_name = "reset";
    word_t       exp_word = '0;
    logic [31:0] cur_addr = '0;              // address of the outstanding request
    logic        exp_load = 1'b0;
    logic        pending = 1'b0;
    int          stall_max = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          rd_count = 0;
    int          wb_count = 0;

    clock_gen #(.RESET_CYCLES(16)) u_clk (.clk(clk), .reset(reset));

    cache_top dut (.*);

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];   // upper bits have the longer period
    endfunction

    function automatic word_t fill_word(int a);
        return (32'(a) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t data, strb_t strb);
        word_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // word a load sees; a store is merged into the expected memory
    function automatic word_t reference_access(logic is_store, logic [31:0] addr,
                                               strb_t strb, word_t data);
        word_t old;
        old = ref_mem[addr[13:2]];
        if (is_store) begin
            ref_mem[addr[13:2]] = merge_bytes(old, data, strb);
        end
        return old;
    endfunction

    function automatic block_t expected_line(logic [31:0] addr);
        block_t line;
        for (int w = 0; w < BANKS; w++) begin
            line[w*WORD_W +: WORD_W] = ref_mem[{addr[13:4], 2'(w)}];
        end
        return line;
    endfunction

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - test_errors);
        end
    endtask

    // one cpu request with its latency counted from the accepting edge
    task automatic access(input logic is_store, input logic [31:0] addr, input strb_t strb,
                          input word_t data, output int latency);
        @(posedge clk);
        #1;
        valid    = 1'b1;
        op       = is_store;
        tag      = addr[31:12];
        index    = addr[11:4];
        offset   = addr[3:0];
        wstrb    = strb;
        wdata    = data;
        cur_addr = addr;
        exp_load = !is_store;
        exp_word = reference_access(is_store, addr, strb, data);
        pending  = 1'b1;
        do @(negedge clk); while (!addr_ok);
        @(posedge clk);
        #1;
        valid   = 1'b0;
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
        end while (!data_ok);
        #1;
        pending = 1'b0;
    endtask

    // random stall followed by one ready cycle
    task automatic grant_request(input logic is_write);
        repeat (lcg_next() % (stall_max + 1)) @(posedge clk);
        @(posedge clk);
        #1;
        if (is_write) begin
            wr_rdy = 1'b1;
        end else begin
            rd_rdy = 1'b1;
        end
        @(posedge clk);
        #1;
        wr_rdy = 1'b0;
        rd_rdy = 1'b0;
    endtask

    initial begin : bus_model
        logic [31:0] line_addr;
        int          gap;

        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            if (!reset && wr_req) begin
                wb_count++;
                line_addr = wr_addr;
                assert (line_addr[11:0] === {cur_addr[11:4], 4'h0}) else begin
                    $display("write-back address %h is not an aligned line of set %h",
                             line_addr, cur_addr[11:4]);
                    errors++;
                end
                assert (wr_data === expected_line(line_addr)) else begin
                    $display("ERR %s expected %h actual %h", test_name,
                             expected_line(line_addr), wr_data);
                    errors++;
                end
                for (int w = 0; w < BANKS; w++) begin
                    bus_mem[{line_addr[13:4], 2'(w)}] = wr_data[w*WORD_W +: WORD_W];
                end
                grant_request(1'b1);
            end else if (!reset && rd_req) begin
                rd_count++;
                line_addr = rd_addr;
                assert (line_addr === {cur_addr[31:4], 4'h0}) else begin
                    $display("ERR %s expected %h actual %h", test_name,
                             {cur_addr[31:4], 4'h0}, line_addr);
                    errors++;
                end
                grant_request(1'b0);
                for (int b = 0; b < BANKS; b++) begin
                    gap       = lcg_next() % (stall_max + 1);
                    ret_valid = 1'b0;
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                    end
                    ret_valid = 1'b1;
                    ret_last  = (b == BANKS - 1);
                    ret_data  = bus_mem[{line_addr[13:4], 2'(b)}];
                    @(posedge clk);
                    #1;
                end
                ret_valid = 1'b0;
                ret_last  = 1'b0;
            end
        end
    end

    // every completion against the reference
    always @(negedge clk) begin
        if (!reset && data_ok) begin
            assert (pending) else begin
                $display("data_ok pulsed with no request outstanding");
                errors++;
            end
            if (exp_load) begin
                assert (rdata === exp_word) else begin
                    $display("ERR %s expected %h actual %h", test_name, exp_word, rdata);
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    initial begin : stimulus
        int          lat;
        int          wb_before;
        logic [15:0] r;
        logic [31:0] addr;

        valid  = 1'b0;
        op     = 1'b0;
        index  = '0;
        tag    = '0;
        offset = '0;
        wstrb  = '0;
        wdata  = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            bus_mem[i] = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        do @(negedge clk); while (reset);

        begin_test("reset");
        assert (addr_ok && !data_ok && !rd_req && !wr_req) else begin
            $display("outputs wrong after reset: addr_ok %b data_ok %b rd_req %b wr_req %b",
                     addr_ok, data_ok, rd_req, wr_req);
            errors++;
        end
        end_test();

        begin_test("read_miss_hit");
        access(1'b0, 32'h0000_1058, 4'h0, '0, lat);     // tag 1, set 5, word 2
        assert (rd_count == 1) else begin
            $display("read miss did not issue exactly one bus read");
            errors++;
        end
        access(1'b0, 32'h0000_1058, 4'h0, '0, lat);
        assert (lat == 1) else begin
            $display("ERR %s expected %0d actual %0d", test_name, 1, lat);
            errors++;
        end
        assert (rd_count == 1) else begin
            $display("reread of a resident line went to the bus");
            errors++;
        end
        end_test();

        begin_test("byte_stores");
        access(1'b1, 32'h0000_1054, 4'b0101, 32'hdead_beef, lat);   // resident line
        access(1'b0, 32'h0000_1054, 4'h0, '0, lat);
        access(1'b1, 32'h0000_209c, 4'b1100, 32'h1234_5678, lat);   // absent line
        access(1'b0, 32'h0000_209c, 4'h0, '0, lat);
        access(1'b0, 32'h0000_2094, 4'h0, '0, lat);
        end_test();

        begin_test("eviction");
        wb_before = wb_count;
        for (int k = 0; k < 3; k++) begin
            access(1'b1, {18'd0, 2'(k), 12'h144}, 4'hf, {lcg_next(), lcg_next()}, lat);
        end
        for (int k = 0; k < 3; k++) begin
            access(1'b0, {18'd0, 2'(k), 12'h144}, 4'h0, '0, lat);
        end
        assert (wb_count > wb_before) else begin
            $display("three dirty lines in one set caused no write-back");
            errors++;
        end
        end_test();

        begin_test("random_mix");
        stall_max = 3;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r    = lcg_next();
            addr = {18'd0, r[1:0], 5'd0, r[4:2], r[6:5], 2'b00};
            access(r[7], addr, r[11:8], {lcg_next(), lcg_next()}, lat);
        end
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
logic/cache_pkg.sv
logic/sync_ram.sv
logic/cache_way.sv
logic/cache_ctrl.sv
logic/miss_sequencer.sv
logic/cache_top.sv
tb/clock_gen.sv
tb/cache_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module cache_tb -o cache_sim
out=$(./obj_dir/cache_sim)
echo "$out"
if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
else
    exit 1
fi
